/* wave_capture_pkg.sv */
package wave_capture_pkg;

  // adc word layout
  parameter int LANES        = 8;
  parameter int LANE_WIDTH   = 16;
  parameter int SAMPLE_WIDTH = 12;

  // output and timestamp widths
  parameter int DMA_WIDTH = 64;
  parameter int TS_WIDTH  = 32;

  // eight lanes, sample right-aligned in each
  typedef logic [LANES*LANE_WIDTH-1:0] adc_word_t;

  typedef logic [DMA_WIDTH-1:0] dma_beat_t;

  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // word index counted from reset
  typedef logic [TS_WIDTH-1:0] timestamp_t;

  typedef enum logic [1:0] {
    ST_PREFILL,
    ST_ARMED,
    ST_POST,
    ST_READOUT
  } ctrl_state_t;

endpackage

/* word_stream_if.sv */
`timescale 1ns/1ps

interface word_stream_if;

  logic                       valid;
  logic                       ready;
  wave_capture_pkg::adc_word_t data;
  // final word of the window
  logic                       last;

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

/* trigger_detect.sv */
`timescale 1ns/1ps

module trigger_detect (
  input  logic                         aclk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  wave_capture_pkg::adc_word_t  in_data,
  input  wave_capture_pkg::sample_t    threshold,
  output logic                         trig_edge,
  output wave_capture_pkg::timestamp_t word_index
);

  logic over;
  logic prev_over;

  // any lane at or above threshold
  always_comb
  begin
    over = 1'b0;
    for (int l = 0; l < wave_capture_pkg::LANES; l++)
    begin
      if (in_data[l*wave_capture_pkg::LANE_WIDTH +: wave_capture_pkg::SAMPLE_WIDTH] >= threshold)
      begin
        over = 1'b1;
      end
    end
  end

  assign trig_edge = in_valid && over && !prev_over;

  // index of the word currently presented
  always_ff @(posedge aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prev_over  <= 1'b0;
      word_index <= '0;
    end
    else if (in_valid)
    begin
      prev_over  <= over;
      word_index <= word_index + 1'b1;
    end
  end

endmodule

/* capture_ctrl.sv */
`timescale 1ns/1ps

module capture_ctrl #(
  parameter int PRE_LEN  = 12,
  parameter int POST_LEN = 38
) (
  input  logic                         aclk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  logic                         trig_edge,
  input  wave_capture_pkg::timestamp_t word_index,
  input  logic                         rd_done,
  input  logic                         frame_done,
  output logic                         wr_en,
  output logic                         rd_start,
  output logic                         ts_valid,
  output wave_capture_pkg::timestamp_t timestamp,
  output logic                         armed
);

  localparam int ACQ_LEN = PRE_LEN + POST_LEN;
  localparam int CNT_W   = $clog2(ACQ_LEN + 1);
  localparam logic [CNT_W-1:0] PRE_LAST  = CNT_W'(PRE_LEN - 1);
  localparam logic [CNT_W-1:0] POST_LAST = CNT_W'(POST_LEN - 1);

  wave_capture_pkg::ctrl_state_t state;
  logic [CNT_W-1:0]              cnt;
  // ring has sent its last word
  logic                          drained;

  // nothing is stored while the window is read out
  assign wr_en = in_valid && (state != wave_capture_pkg::ST_READOUT);
  assign armed = (state == wave_capture_pkg::ST_ARMED);

  always_ff @(posedge aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= wave_capture_pkg::ST_PREFILL;
      cnt      <= '0;
      rd_start <= 1'b0;
      ts_valid <= 1'b0;
      drained  <= 1'b0;
    end
    else
    begin
      rd_start <= 1'b0;
      case (state)
        wave_capture_pkg::ST_PREFILL:
        begin
          if (in_valid)
          begin
            if (cnt == PRE_LAST)
            begin
              state <= wave_capture_pkg::ST_ARMED;
              cnt   <= '0;
            end
            else
            begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        wave_capture_pkg::ST_ARMED:
        begin
          // trigger word is the first post word
          if (trig_edge)
          begin
            if (POST_LAST == '0)
            begin
              state    <= wave_capture_pkg::ST_READOUT;
              rd_start <= 1'b1;
              ts_valid <= 1'b1;
            end
            else
            begin
              state <= wave_capture_pkg::ST_POST;
              cnt   <= CNT_W'(1);
            end
          end
        end
        wave_capture_pkg::ST_POST:
        begin
          if (in_valid)
          begin
            if (cnt == POST_LAST)
            begin
              state    <= wave_capture_pkg::ST_READOUT;
              cnt      <= '0;
              rd_start <= 1'b1;
              ts_valid <= 1'b1;
            end
            else
            begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default:
        begin
          if (rd_done)
          begin
            drained <= 1'b1;
          end
          if (frame_done && (drained || rd_done))
          begin
            state    <= wave_capture_pkg::ST_PREFILL;
            ts_valid <= 1'b0;
            drained  <= 1'b0;
          end
        end
      endcase
    end
  end

  // latch index of the trigger word
  always_ff @(posedge aclk)
  begin
    if (armed && trig_edge)
    begin
      timestamp <= word_index;
    end
  end

endmodule

/* ring_buffer.sv */
`timescale 1ns/1ps

module ring_buffer #(
  parameter int DEPTH = 50
) (
  input  logic                        aclk,
  input  logic                        rst_n,
  input  logic                        wr_en,
  input  wave_capture_pkg::adc_word_t wr_data,
  input  logic                        rd_start,
  output logic                        rd_done,
  word_stream_if.source               words
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEPTH - 1);

  wave_capture_pkg::adc_word_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] rd_cnt;
  logic             rd_active;
  logic             fetch;

  // output register free or draining this cycle
  assign fetch = rd_active && (!words.valid || words.ready);

  always_ff @(posedge aclk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= wr_data;
    end
    if (fetch)
    begin
      words.data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      rd_cnt      <= '0;
      rd_active   <= 1'b0;
      words.valid <= 1'b0;
      words.last  <= 1'b0;
      rd_done     <= 1'b0;
    end
    else
    begin
      rd_done <= words.valid && words.ready && words.last;
      if (wr_en)
      begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_start)
      begin
        // write pointer sits on the oldest entry
        rd_ptr    <= wr_ptr;
        rd_cnt    <= '0;
        rd_active <= 1'b1;
      end
      else if (fetch)
      begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == CNT_LAST)
        begin
          rd_active <= 1'b0;
        end
      end
      if (fetch)
      begin
        words.valid <= 1'b1;
        words.last  <= (rd_cnt == CNT_LAST);
      end
      else if (words.ready)
      begin
        words.valid <= 1'b0;
      end
    end
  end

endmodule

/* width_converter.sv */
`timescale 1ns/1ps

module width_converter (
  input  logic                        aclk,
  input  logic                        rst_n,
  word_stream_if.sink                 words,
  output logic                        beat_valid,
  input  logic                        beat_ready,
  output wave_capture_pkg::dma_beat_t beat_data,
  output logic                        beat_last
);

  localparam int BW = $bits(wave_capture_pkg::dma_beat_t);

  wave_capture_pkg::adc_word_t word_q;
  logic                        last_q;
  // high half on the output
  logic                        half;

  // take a new word once the high half leaves
  assign words.ready = !beat_valid || (half && beat_ready);

  assign beat_data = half ? word_q[2*BW-1:BW] : word_q[BW-1:0];
  assign beat_last = half && last_q;

  always_ff @(posedge aclk)
  begin
    if (words.valid && words.ready)
    begin
      word_q <= words.data;
    end
  end

  always_ff @(posedge aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      beat_valid <= 1'b0;
      half       <= 1'b0;
      last_q     <= 1'b0;
    end
    else if (words.valid && words.ready)
    begin
      beat_valid <= 1'b1;
      half       <= 1'b0;
      last_q     <= words.last;
    end
    else if (beat_valid && beat_ready)
    begin
      if (!half)
      begin
        half <= 1'b1;
      end
      else
      begin
        beat_valid <= 1'b0;
      end
    end
  end

endmodule

/* stream_framer.sv */
`timescale 1ns/1ps

module stream_framer (
  input  logic                         aclk,
  input  logic                         rst_n,
  input  logic                         ts_valid,
  input  wave_capture_pkg::timestamp_t timestamp,
  input  logic                         beat_valid,
  output logic                         beat_ready,
  input  wave_capture_pkg::dma_beat_t  beat_data,
  input  logic                         beat_last,
  output wave_capture_pkg::dma_beat_t  m_axis_tdata,
  output logic                         m_axis_tvalid,
  output logic                         m_axis_tuser,
  output logic                         m_axis_tlast,
  input  logic                         m_axis_tready,
  output logic                         frame_done
);

  logic out_free;
  logic load_hdr;
  // frame open until its tlast beat leaves
  logic busy;
  // header sent, data beats flowing
  logic pass;

  assign out_free   = !m_axis_tvalid || m_axis_tready;
  assign load_hdr   = ts_valid && !busy && out_free;
  assign beat_ready = pass && out_free;
  assign frame_done = m_axis_tvalid && m_axis_tready && m_axis_tlast;

  always_ff @(posedge aclk)
  begin
    if (load_hdr)
    begin
      m_axis_tdata <= wave_capture_pkg::dma_beat_t'(timestamp);
    end
    else if (beat_valid && beat_ready)
    begin
      m_axis_tdata <= beat_data;
    end
  end

  always_ff @(posedge aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      m_axis_tvalid <= 1'b0;
      m_axis_tuser  <= 1'b0;
      m_axis_tlast  <= 1'b0;
      busy          <= 1'b0;
      pass          <= 1'b0;
    end
    else
    begin
      if (frame_done)
      begin
        busy <= 1'b0;
      end
      if (load_hdr)
      begin
        m_axis_tvalid <= 1'b1;
        m_axis_tuser  <= 1'b1;
        m_axis_tlast  <= 1'b0;
        busy          <= 1'b1;
        pass          <= 1'b1;
      end
      else if (beat_valid && beat_ready)
      begin
        m_axis_tvalid <= 1'b1;
        m_axis_tuser  <= 1'b0;
        m_axis_tlast  <= beat_last;
        if (beat_last)
        begin
          pass <= 1'b0;
        end
      end
      else if (m_axis_tready)
      begin
        m_axis_tvalid <= 1'b0;
      end
    end
  end

endmodule

/* wave_capture_top.sv */
`timescale 1ns/1ps

module wave_capture_top #(
  parameter int PRE_LEN  = 12,
  parameter int POST_LEN = 38
) (
  input  logic                        aclk,
  input  logic                        rst_n,
  input  wave_capture_pkg::sample_t   threshold,
  input  wave_capture_pkg::adc_word_t s_axis_tdata,
  input  logic                        s_axis_tvalid,
  output logic                        s_axis_tready,
  output wave_capture_pkg::dma_beat_t m_axis_tdata,
  output logic                        m_axis_tvalid,
  input  logic                        m_axis_tready,
  output logic                        m_axis_tlast,
  output logic                        m_axis_tuser,
  output logic                        armed
);

  localparam int ACQ_LEN = PRE_LEN + POST_LEN;

  logic                         in_valid;
  logic                         trig_edge;
  wave_capture_pkg::timestamp_t word_index;
  wave_capture_pkg::timestamp_t timestamp;
  logic                         wr_en;
  logic                         rd_start;
  logic                         rd_done;
  logic                         ts_valid;
  logic                         frame_done;
  logic                         beat_valid;
  logic                         beat_ready;
  wave_capture_pkg::dma_beat_t  beat_data;
  logic                         beat_last;

  word_stream_if words ();

  // adc never stalls, ready once out of reset
  always_ff @(posedge aclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s_axis_tready <= 1'b0;
    end
    else
    begin
      s_axis_tready <= 1'b1;
    end
  end

  assign in_valid = s_axis_tvalid && s_axis_tready;

  trigger_detect i_trigger_detect (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (s_axis_tdata),
    .threshold  (threshold),
    .trig_edge  (trig_edge),
    .word_index (word_index)
  );

  capture_ctrl #(
    .PRE_LEN  (PRE_LEN),
    .POST_LEN (POST_LEN)
  ) i_capture_ctrl (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .trig_edge  (trig_edge),
    .word_index (word_index),
    .rd_done    (rd_done),
    .frame_done (frame_done),
    .wr_en      (wr_en),
    .rd_start   (rd_start),
    .ts_valid   (ts_valid),
    .timestamp  (timestamp),
    .armed      (armed)
  );

  ring_buffer #(
    .DEPTH (ACQ_LEN)
  ) i_ring_buffer (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_data  (s_axis_tdata),
    .rd_start (rd_start),
    .rd_done  (rd_done),
    .words    (words.source)
  );

  width_converter i_width_converter (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .words      (words.sink),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .beat_data  (beat_data),
    .beat_last  (beat_last)
  );

  stream_framer i_stream_framer (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .ts_valid      (ts_valid),
    .timestamp     (timestamp),
    .beat_valid    (beat_valid),
    .beat_ready    (beat_ready),
    .beat_data     (beat_data),
    .beat_last     (beat_last),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .frame_done    (frame_done)
  );

endmodule

/* tb_wave_capture.sv */
`timescale 1ns/1ps

module tb_wave_capture;

  localparam int PRE_LEN       = 4;
  localparam int POST_LEN      = 6;
  localparam int ACQ_LEN       = PRE_LEN + POST_LEN;
  localparam int FRAME_BEATS   = 1 + 2 * ACQ_LEN;
  localparam int FRAME_TIMEOUT = 400;
  localparam int TOTAL_FRAMES  = 9;

  logic                         aclk;
  logic                         rst_n;
  wave_capture_pkg::sample_t    threshold;
  wave_capture_pkg::adc_word_t  s_axis_tdata;
  logic                         s_axis_tvalid;
  logic                         s_axis_tready;
  wave_capture_pkg::dma_beat_t  m_axis_tdata;
  logic                         m_axis_tvalid;
  logic                         m_axis_tready;
  logic                         m_axis_tlast;
  logic                         m_axis_tuser;
  logic                         armed;

  integer seed;
  logic   gaps_on;
  logic   bp_on;
  int     frames;
  // first word index of the current pre-fill
  int     resume_idx;

  wave_capture_pkg::adc_word_t words_q[$];
  // {tuser, tlast, tdata}
  logic [65:0]                 exp_q[$];

  logic                        hold_pend;
  wave_capture_pkg::dma_beat_t held_data;
  logic                        held_user;
  logic                        held_last;

  wave_capture_top #(
    .PRE_LEN  (PRE_LEN),
    .POST_LEN (POST_LEN)
  ) i_wave_capture_top (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .threshold     (threshold),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tuser  (m_axis_tuser),
    .armed         (armed)
  );

  initial
  begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_beat(input string name, input wave_capture_pkg::dma_beat_t exp,
                            input wave_capture_pkg::dma_beat_t act);
    if (act !== exp)
    begin
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_timestamp(input string name, input wave_capture_pkg::timestamp_t exp,
                                 input wave_capture_pkg::timestamp_t act);
    if (act !== exp)
    begin
      $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic is_over(input wave_capture_pkg::adc_word_t w);
    logic hit;
    hit = 1'b0;
    for (int l = 0; l < wave_capture_pkg::LANES; l++)
    begin
      if (w[l*wave_capture_pkg::LANE_WIDTH +: wave_capture_pkg::SAMPLE_WIDTH] >= threshold)
      begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // first rising crossing once pre-fill is complete, -1 if none yet
  function automatic int find_trigger(input int start, input int count);
    for (int i = start + PRE_LEN; i < count; i++)
    begin
      if (is_over(words_q[i]) && (i == 0 || !is_over(words_q[i-1])))
      begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic logic expected_armed(input int count);
    if (count - resume_idx < PRE_LEN)
    begin
      return 1'b0;
    end
    return find_trigger(resume_idx, count) < 0;
  endfunction

  function automatic logic [65:0] expected_beat(input int trig, input int n);
    wave_capture_pkg::adc_word_t w;
    wave_capture_pkg::dma_beat_t data;
    logic                        last;
    if (n == 0)
    begin
      data = wave_capture_pkg::dma_beat_t'(wave_capture_pkg::timestamp_t'(trig));
      return {1'b1, 1'b0, data};
    end
    // window starts PRE_LEN words before the trigger, low half first
    w    = words_q[trig - PRE_LEN + (n - 1) / 2];
    data = ((n - 1) % 2 == 0) ? w[63:0] : w[127:64];
    last = (n == FRAME_BEATS - 1);
    return {1'b0, last, data};
  endfunction

  task automatic compare_beat();
    logic [65:0] exp;
    int          trig;
    if (m_axis_tuser === 1'b1)
    begin
      trig = find_trigger(resume_idx, words_q.size());
      if (exp_q.size() != 0 || trig < 0 || trig + POST_LEN > words_q.size())
      begin
        $display("frame header at %0t does not match any completed capture", $time);
        abort_run();
      end
      check_timestamp("m_axis_tdata[31:0]", wave_capture_pkg::timestamp_t'(trig),
                      m_axis_tdata[31:0]);
      for (int n = 0; n < FRAME_BEATS; n++)
      begin
        exp_q.push_back(expected_beat(trig, n));
      end
    end
    if (exp_q.size() == 0)
    begin
      $display("output beat at %0t arrived outside of any frame", $time);
      abort_run();
    end
    exp = exp_q.pop_front();
    check_beat("m_axis_tdata", exp[63:0], m_axis_tdata);
    check_flag("m_axis_tuser", exp[65], m_axis_tuser);
    check_flag("m_axis_tlast", exp[64], m_axis_tlast);
    if (m_axis_tlast)
    begin
      frames++;
      resume_idx = words_q.size();
    end
  endtask

  // transfers happen at the next rising edge, so sample at the falling one
  always @(negedge aclk)
  begin
    if (rst_n)
    begin
      check_flag("armed", expected_armed(words_q.size()), armed);
      if (hold_pend)
      begin
        check_flag("m_axis_tvalid", 1'b1, m_axis_tvalid);
        check_beat("m_axis_tdata", held_data, m_axis_tdata);
        check_flag("m_axis_tuser", held_user, m_axis_tuser);
        check_flag("m_axis_tlast", held_last, m_axis_tlast);
      end
      hold_pend = m_axis_tvalid && !m_axis_tready;
      held_data = m_axis_tdata;
      held_user = m_axis_tuser;
      held_last = m_axis_tlast;
      if (s_axis_tvalid)
      begin
        // adc words are never stalled
        check_flag("s_axis_tready", 1'b1, s_axis_tready);
        words_q.push_back(s_axis_tdata);
      end
      if (m_axis_tvalid && m_axis_tready)
      begin
        compare_beat();
      end
    end
  end

  task automatic next_cycle();
    @(posedge aclk);
    #1;
    if (bp_on)
    begin
      m_axis_tready = (($random(seed) & 3) != 0);
    end
    else
    begin
      m_axis_tready = 1'b1;
    end
  endtask

  task automatic make_word(input logic over_thr, input int lane, input logic exact,
                           output wave_capture_pkg::adc_word_t w);
    wave_capture_pkg::sample_t s;
    w = '0;
    for (int l = 0; l < wave_capture_pkg::LANES; l++)
    begin
      s = wave_capture_pkg::sample_t'(($random(seed) & 32'hffff) % threshold);
      w[l*wave_capture_pkg::LANE_WIDTH +: wave_capture_pkg::SAMPLE_WIDTH] = s;
    end
    if (over_thr)
    begin
      if (exact)
      begin
        s = threshold;
      end
      else
      begin
        s = wave_capture_pkg::sample_t'(threshold +
              (($random(seed) & 32'hffff) % (4096 - threshold)));
      end
      w[lane*wave_capture_pkg::LANE_WIDTH +: wave_capture_pkg::SAMPLE_WIDTH] = s;
    end
  endtask

  task automatic send_word(input wave_capture_pkg::adc_word_t w);
    int gap;
    gap = gaps_on ? ($random(seed) & 3) : 0;
    s_axis_tvalid = 1'b0;
    repeat (gap) next_cycle();
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = w;
    next_cycle();
    s_axis_tvalid = 1'b0;
  endtask

  task automatic send_low(input int count);
    wave_capture_pkg::adc_word_t w;
    repeat (count)
    begin
      make_word(1'b0, 0, 1'b0, w);
      send_word(w);
    end
  endtask

  task automatic send_over(input int lane, input logic exact);
    wave_capture_pkg::adc_word_t w;
    make_word(1'b1, lane, exact, w);
    send_word(w);
  endtask

  task automatic wait_frames(input int target);
    int cycles;
    cycles = 0;
    s_axis_tvalid = 1'b0;
    while (frames < target)
    begin
      if (cycles == FRAME_TIMEOUT)
      begin
        $display("timed out waiting for frame %0d at %0t", target, $time);
        abort_run();
      end
      next_cycle();
      cycles++;
    end
  endtask

  initial
  begin
    wave_capture_pkg::adc_word_t w;
    int                          sent;
    seed          = 37849;
    rst_n         = 1'b0;
    threshold     = 12'h800;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b1;
    gaps_on       = 1'b0;
    bp_on         = 1'b0;
    frames        = 0;
    resume_idx    = 0;
    hold_pend     = 1'b0;
    repeat (10) @(posedge aclk);
    #1;
    rst_n = 1'b1;
    sent  = 0;
    while (s_axis_tready !== 1'b1)
    begin
      if (sent == 20)
      begin
        $display("s_axis_tready never went high after reset");
        abort_run();
      end
      next_cycle();
      sent++;
    end

    // crossing on word 0 falls in pre-fill, the later one triggers
    send_over(0, 1'b0);
    send_low(PRE_LEN + 1);
    send_over(3, 1'b0);
    send_low(POST_LEN - 1);
    wait_frames(1);

    // crossing during pre-fill after a frame is ignored
    send_low(1);
    send_over(5, 1'b0);
    send_low(2 + 3);
    repeat (5) next_cycle();
    check_flag("armed", 1'b1, armed);
    if (frames != 1)
    begin
      $display("a frame was produced for a crossing inside pre-fill");
      abort_run();
    end
    send_over(7, 1'b1);
    send_low(POST_LEN - 1);
    wait_frames(2);

    // a run of over-threshold words across arming, then crossings during readout
    send_low(PRE_LEN - 1);
    send_over(1, 1'b0);
    send_over(1, 1'b0);
    send_over(1, 1'b0);
    send_low(1);
    send_over(1, 1'b0);
    send_low(POST_LEN - 1);
    sent = 0;
    while (frames < 3)
    begin
      if (sent == FRAME_TIMEOUT)
      begin
        $display("timed out waiting for frame 3 while streaming during readout");
        abort_run();
      end
      make_word(sent % 3 == 2, 4, 1'b0, w);
      send_word(w);
      sent++;
    end
    send_low(PRE_LEN + 2);
    send_over(2, 1'b0);
    send_low(POST_LEN - 1);
    wait_frames(4);

    // input gaps first, then output back-pressure as well
    gaps_on = 1'b1;
    for (int k = 0; k < 5; k++)
    begin
      bp_on = (k >= 2);
      send_low(PRE_LEN + 1);
      // trigger lane walks 4, 5, 6, 7, 0
      send_over((k + 4) % 8, k % 2 == 1);
      send_low(POST_LEN - 1);
      wait_frames(5 + k);
    end
    bp_on = 1'b0;
    repeat (30) next_cycle();

    if (frames == TOTAL_FRAMES && exp_q.size() == 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      $display("saw %0d frames with %0d beats still pending", frames, exp_q.size());
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule

/* wave_capture.f */
wave_capture_pkg.sv
word_stream_if.sv
trigger_detect.sv
capture_ctrl.sv
ring_buffer.sv
width_converter.sv
stream_framer.sv
wave_capture_top.sv
tb_wave_capture.sv
